// File: sources.f
hw/status_gen_pkg.sv
hw/status_cmd_regs.sv
hw/status_watch.sv
hw/status_packetizer.sv
hw/status_generate.sv
tests/tb_clock_gen.sv
tests/tb_status_generate.sv

// File: Bender.yml
package:
  name: status_generate

sources:
  - files:
      - hw/status_gen_pkg.sv
      - hw/status_cmd_regs.sv
      - hw/status_watch.sv
      - hw/status_packetizer.sv
      - hw/status_generate.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_status_generate.sv

// File: tests/tb_status_generate.sv
// status reporter testbench
`default_nettype none

module tb_status_generate;

    localparam int PAYLOAD_BITS = 15;
    localparam int NUM_BYTES    = (PAYLOAD_BITS + 21) / 8; // address + payload bytes
    localparam int ADDR         = 7;                       // default address byte
    localparam int NUM_STEPS    = 14;
    localparam int MAX_PACKETS  = 4;                       // per step, guards a packet storm

    wire                     rst;    // clock
    wire                     clk;    // reset
    logic                    srst;
    logic                    we;
    logic [7:0]              wd;
    logic [PAYLOAD_BITS-1:0] status;
    logic                    start;
    wire  [7:0]              ad;
    wire                     rq;

    // stimulus and expected values, one entry per step
    string                   step_name   [NUM_STEPS];
    bit                      step_wr     [NUM_STEPS]; // write wd
    logic [7:0]              step_wd     [NUM_STEPS];
    bit                      step_srst   [NUM_STEPS]; // pulse srst
    logic [PAYLOAD_BITS-1:0] step_status [NUM_STEPS];
    int                      step_quiet  [NUM_STEPS]; // idle cycles that end the step
    int                      step_count  [NUM_STEPS]; // expected packets
    logic [5:0]              step_seq    [NUM_STEPS]; // expected seq in every packet

    logic [31:0] lcg_state;
    int          step_errors;
    int          total_errors;
    int          failed_steps;
    bit          timed_out;

    tb_clock_gen u_clock_gen (
        .rst (rst),
        .clk (clk)
    );

    status_generate DUT (
        .rst    (rst),
        .clk    (clk),
        .srst   (srst),
        .we     (we),
        .wd     (wd),
        .status (status),
        .start  (start),
        .ad     (ad),
        .rq     (rq)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345; // wraps at 32 bits
    endfunction

    // payload bytes packed low byte first
    function automatic logic [31:0] expected_payload(input logic [5:0] s,
                                                     input logic [PAYLOAD_BITS-1:0] st);
        logic [31:0] p;
        p = '0;                                   // zeros above the status
        p[7:0] = {s, st[1:0]};                    // seq on top of status[1:0]
        p[PAYLOAD_BITS+5:8] = st[PAYLOAD_BITS-1:2];
        return p;
    endfunction

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s %s expected 0x%0h actual 0x%0h", name, field, expected, actual);
            step_errors++;
        end
    endtask

    task automatic set_step(input int idx, input string name, input bit wr, input logic [7:0] w,
                            input bit sr, input logic [PAYLOAD_BITS-1:0] st, input int quiet,
                            input int cnt, input logic [5:0] sq);
        step_name[idx]   = name;
        step_wr[idx]     = wr;
        step_wd[idx]     = w;
        step_srst[idx]   = sr;
        step_status[idx] = st;
        step_quiet[idx]  = quiet;
        step_count[idx]  = cnt;
        step_seq[idx]    = sq;
    endtask

    task automatic load_table();
        set_step(0,  "reset_idle",     0, 8'h00, 0, 15'h0000, 20, 0, 6'h00);
        set_step(1,  "single_write",   1, 8'h55, 0, 15'h2D6B, 30, 1, 6'h15); // mode 1 seq 0x15
        set_step(2,  "off_write",      1, 8'h0A, 0, 15'h1234, 30, 0, 6'h00);
        set_step(3,  "off_change",     0, 8'h00, 0, 15'h0F0F, 30, 0, 6'h00);
        set_step(4,  "keep_enable",    1, 8'hAA, 0, 15'h0F0F, 30, 1, 6'h2A); // mode 2
        set_step(5,  "keep_change_a",  0, 8'h00, 0, 15'h7001, 30, 1, 6'h2A);
        set_step(6,  "keep_change_b",  0, 8'h00, 0, 15'h0003, 30, 1, 6'h2A);
        set_step(7,  "keep_same",      0, 8'h00, 0, 15'h0003, 30, 0, 6'h00);
        set_step(8,  "inc_enable",     1, 8'hFE, 0, 15'h0003, 30, 1, 6'h3E); // mode 3
        set_step(9,  "inc_change_a",   0, 8'h00, 0, 15'h4444, 30, 1, 6'h3F);
        set_step(10, "inc_change_b",   0, 8'h00, 0, 15'h1555, 30, 1, 6'h00); // seq wraps
        set_step(11, "inc_change_c",   0, 8'h00, 0, 15'h6AAA, 30, 1, 6'h01);
        set_step(12, "srst_in_auto",   0, 8'h00, 1, 15'h1111, 30, 0, 6'h00); // rq high at srst
        set_step(13, "off_after_srst", 0, 8'h00, 0, 15'h0101, 30, 0, 6'h00);
    endtask

    task automatic wait_reset_release(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < 40 && !ok; n++) begin
            @(negedge rst);
            if (!clk) ok = 1'b1;
        end
    endtask

    // downstream model, acks every request until the bus stays quiet
    task automatic serve_window(input int i, output int npk);
        int          idle;
        int          dly;
        int          k;
        logic [31:0] exp_pl;
        npk = 0;
        idle = 0;
        exp_pl = expected_payload(step_seq[i], step_status[i]);
        while (idle < step_quiet[i] && npk < MAX_PACKETS) begin
            @(negedge rst);
            check_value(step_name[i], "ad idle", ADDR, ad); // address also while waiting
            if (!rq) begin
                idle++;
            end else begin
                lcg_state = lcg_step(lcg_state);
                dly = (lcg_state >> 16) % 6; // 0..5 cycles of back-pressure
                repeat (dly) @(posedge rst);
                @(posedge rst);
                start <= 1'b1;
                @(negedge rst);
                check_value(step_name[i], "ad addr", ADDR, ad);
                check_value(step_name[i], "rq addr", 1, rq);
                @(posedge rst);
                start <= 1'b0;
                for (k = 1; k < NUM_BYTES; k++) begin
                    @(negedge rst);
                    check_value(step_name[i], $sformatf("byte%0d", k),
                                exp_pl[8*(k-1) +: 8], ad);
                    check_value(step_name[i], $sformatf("rq byte%0d", k),
                                (k < NUM_BYTES - 1), rq); // low only on the last byte
                    if (k == 1) begin
                        check_value(step_name[i], "seq", step_seq[i], ad[7:2]);
                    end
                end
                npk++;
                idle = 0;
            end
        end
        if (npk >= MAX_PACKETS) begin
            $display("step %s did not go quiet, packets kept coming", step_name[i]);
            step_errors++;
        end
    endtask

    task automatic apply_step(input int i);
        int npk;
        step_errors = 0;
        @(posedge rst);
        status <= step_status[i];
        repeat (3) @(posedge rst); // let status_now settle
        if (step_wr[i]) begin
            we <= 1'b1;
            wd <= step_wd[i];
            @(posedge rst);
            we <= 1'b0;
        end
        if (step_srst[i]) begin
            srst <= 1'b1;
            @(posedge rst);
            srst <= 1'b0;
        end
        serve_window(i, npk);
        check_value(step_name[i], "packets", step_count[i], npk);
        if (step_errors == 0) begin
            $display("step %0d %s: ok", i, step_name[i]);
        end else begin
            $display("step %0d %s: %0d errors", i, step_name[i], step_errors);
            failed_steps++;
        end
        total_errors += step_errors;
    endtask

    initial begin
        bit ok;
        int i;
        srst = 1'b0;
        we = 1'b0;
        wd = '0;
        status = '0;
        start = 1'b0;
        lcg_state = 32'd98680;
        total_errors = 0;
        failed_steps = 0;
        timed_out = 1'b0;
        load_table();
        wait_reset_release(ok);
        if (!ok) begin
            $display("timeout: reset still asserted after 40 cycles");
            timed_out = 1'b1;
        end else begin
            for (i = 0; i < NUM_STEPS; i++) begin
                apply_step(i);
            end
        end
        $display("%0d steps, %0d failed, %0d errors", NUM_STEPS, failed_steps, total_errors);
        if (timed_out || total_errors != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
// testbench clock and reset
`default_nettype none

module tb_clock_gen (
    output logic rst, // clock, period 8
    output logic clk  // reset, active high
);

    initial begin
        rst = 1'b0;
        forever #4 rst = ~rst; // half period
    end

    initial begin
        clk = 1'b1;                // held from time 0
        repeat (10) @(posedge rst);
        clk <= 1'b0;               // released on a rising edge
    end

endmodule

`default_nettype wire

// File: hw/status_generate.sv
// byte-serial status reporter
`default_nettype none

module status_generate #(
    parameter int STATUS_REG_ADDR = 7,  // address byte of each packet
    parameter int PAYLOAD_BITS    = 15, // status width, 2..26
    parameter int REGISTER_STATUS = 1   // 1: register status from another domain
) (
    input  wire                         rst,    // clock
    input  wire                         clk,    // async reset, active high
    input  wire                         srst,   // sync reset
    input  wire                         we,     // command write strobe
    input  wire status_gen_pkg::byte_t  wd,     // {mode[1:0], seq[5:0]}
    input  wire [PAYLOAD_BITS-1:0]      status, // parallel status to report
    input  wire                         start,  // ack of the address byte
    output wire status_gen_pkg::byte_t  ad,     // address/data bus
    output wire                         rq      // request, low on the last byte
);

    wire [status_gen_pkg::SEQ_BITS-1:0] seq;            // cmd regs -> packetizer
    wire                                auto_en;        // auto mode enabled
    wire                                cmd_pend;       // single request pending
    wire [PAYLOAD_BITS-1:0]             status_now;     // status after input stage
    wire                                status_changed; // change since last packet

    status_cmd_regs u_cmd_regs (
        .rst      (rst),
        .clk      (clk),
        .srst     (srst),
        .we       (we),
        .wd       (wd),
        .start    (start),
        .seq      (seq),
        .auto_en  (auto_en),
        .cmd_pend (cmd_pend)
    );

    status_watch #(
        .PAYLOAD_BITS    (PAYLOAD_BITS),
        .REGISTER_STATUS (REGISTER_STATUS)
    ) u_watch (
        .rst            (rst),
        .clk            (clk),
        .srst           (srst),
        .status         (status),
        .start          (start),
        .status_now     (status_now),
        .status_changed (status_changed)
    );

    status_packetizer #(
        .STATUS_REG_ADDR (STATUS_REG_ADDR),
        .PAYLOAD_BITS    (PAYLOAD_BITS)
    ) u_packetizer (
        .rst            (rst),
        .clk            (clk),
        .srst           (srst),
        .start          (start),
        .seq            (seq),
        .auto_en        (auto_en),
        .cmd_pend       (cmd_pend),
        .status_now     (status_now),
        .status_changed (status_changed),
        .ad             (ad),
        .rq             (rq)
    );

endmodule

`default_nettype wire

// File: hw/status_packetizer.sv
// status packet byte shifter
`default_nettype none

module status_packetizer #(
    parameter int STATUS_REG_ADDR = 7,  // address byte of the packet
    parameter int PAYLOAD_BITS    = 15  // status width, 2..26
) (
    input  wire                                 rst,            // clock
    input  wire                                 clk,            // async reset, active high
    input  wire                                 srst,           // sync reset
    input  wire                                 start,          // ack of the address byte
    input  wire [status_gen_pkg::SEQ_BITS-1:0]  seq,            // sequence number
    input  wire                                 auto_en,        // auto mode active
    input  wire                                 cmd_pend,       // command asked for a packet
    input  wire [PAYLOAD_BITS-1:0]              status_now,     // status to capture at start
    input  wire                                 status_changed, // status differs from last sent
    output status_gen_pkg::byte_t               ad,             // address/data byte
    output logic                                rq              // low on the last byte
);

    localparam int NUM_BYTES = status_gen_pkg::packet_bytes(PAYLOAD_BITS);
    localparam int DATA_BITS = (NUM_BYTES - 1) * 8; // payload bytes only
    localparam status_gen_pkg::byte_t ADDR_BYTE = status_gen_pkg::byte_t'(STATUS_REG_ADDR);

    logic                 need_send; // something to send
    logic                 snd_rest;  // past the address, more payload to shift
    logic [NUM_BYTES-2:0] rq_r;      // one bit per byte that keeps rq high
    logic [DATA_BITS-1:0] payload_w; // aligned payload from live inputs
    logic [DATA_BITS-1:0] data;      // output shifter, low byte on the bus

    assign need_send = cmd_pend || (auto_en && status_changed);
    assign rq        = rq_r[0];
    // top bit drops at start, so this is the payload phase
    assign snd_rest  = rq_r[0] && !rq_r[NUM_BYTES-2]; // never true for 2-byte packets
    assign ad        = data[7:0];

    // payload layout
    // byte 0: {seq, status[1:0]}, then status[9:2], status[17:10], ...
    always_comb begin
        payload_w = '0; // zero fill above PAYLOAD_BITS
        payload_w[1:0] = status_now[1:0];
        payload_w[2 +: status_gen_pkg::SEQ_BITS] = seq;
        for (int i = 2; i < PAYLOAD_BITS; i++) begin
            payload_w[i + 6] = status_now[i]; // skip over the seq field
        end
    end

    // request shift register
    // all ones while waiting for start, then drains one bit per cycle
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            rq_r <= '0;
        end else if (srst) begin
            rq_r <= '0;
        end else if (need_send && !rq_r[0]) begin
            rq_r <= '1; // NUM_BYTES-1 ones
        end else if (start || snd_rest) begin
            rq_r <= rq_r >> 1;
        end
    end

    // byte shifter
    // address shows whenever no payload is going out
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            data <= DATA_BITS'(ADDR_BYTE);
        end else if (srst) begin
            data <= DATA_BITS'(ADDR_BYTE);
        end else if (start) begin
            data <= payload_w; // status captured at the ack cycle
        end else if (snd_rest) begin
            data <= data >> 8; // next payload byte
        end else begin
            data <= DATA_BITS'(ADDR_BYTE); // idle or waiting
        end
    end

endmodule

`default_nettype wire

// File: hw/status_watch.sv
// status change detector
`default_nettype none

module status_watch #(
    parameter int PAYLOAD_BITS    = 15, // status width, 2..26
    parameter int REGISTER_STATUS = 1   // 1: status comes from another clock domain
) (
    input  wire                     rst,            // clock
    input  wire                     clk,            // async reset, active high
    input  wire                     srst,           // sync reset
    input  wire  [PAYLOAD_BITS-1:0] status,         // raw parallel status
    input  wire                     start,          // downstream ack, freezes the status
    output logic [PAYLOAD_BITS-1:0] status_now,     // registered or direct status
    output logic                    status_changed  // sticky, differs from last sent copy
);

    logic [PAYLOAD_BITS-1:0] status_frz; // copy taken at the last start

    // optional input stage
    if (REGISTER_STATUS != 0) begin : g_reg
        logic [PAYLOAD_BITS-1:0] status_r; // one cycle behind status

        always_ff @(posedge rst or posedge clk) begin
            if (clk) begin
                status_r <= '0;
            end else if (srst) begin
                status_r <= '0;
            end else begin
                status_r <= status;
            end
        end

        assign status_now = status_r;
    end else begin : g_direct
        assign status_now = status; // same clock domain, no lag
    end

    // frozen copy, this is what went out in the last packet
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            status_frz <= '0;
        end else if (srst) begin
            status_frz <= '0;
        end else if (start) begin
            status_frz <= status_now;
        end
    end

    // change flag
    // stays set even if the status goes back to the frozen value
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            status_changed <= 1'b0;
        end else if (srst) begin
            status_changed <= 1'b0;
        end else if (start) begin
            status_changed <= 1'b0; // new reference taken this cycle
        end else begin
            status_changed <= status_changed || (status_frz != status_now);
        end
    end

endmodule

`default_nettype wire

// File: hw/status_cmd_regs.sv
// status command register
`default_nettype none

module status_cmd_regs (
    input  wire                                 rst,      // clock
    input  wire                                 clk,      // async reset, active high
    input  wire                                 srst,     // sync reset
    input  wire                                 we,       // command write strobe
    input  wire status_gen_pkg::byte_t          wd,       // {mode, seq}
    input  wire                                 start,    // downstream ack of the address byte
    output logic [status_gen_pkg::SEQ_BITS-1:0] seq,      // sequence number sent in payload
    output logic                                auto_en,  // auto modes, mode bit 1
    output logic                                cmd_pend  // send requested by a command write
);

    status_gen_pkg::status_mode_e        mode;   // current mode
    status_gen_pkg::status_mode_e        mode_w; // mode field of wd
    logic [status_gen_pkg::SEQ_BITS-1:0] seq_w;  // seq field of wd

    // split the command byte
    assign mode_w  = status_gen_pkg::status_mode_e'(wd[status_gen_pkg::MODE_LSB +: 2]);
    assign seq_w   = wd[status_gen_pkg::SEQ_BITS-1:0];
    assign auto_en = mode[1]; // both auto modes have bit 1 set

    // mode register
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            mode <= status_gen_pkg::MODE_OFF;
        end else if (srst) begin
            mode <= status_gen_pkg::MODE_OFF;
        end else if (we) begin
            mode <= mode_w;
        end
    end

    // sequence number, a write wins over the auto increment
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            seq <= '0;
        end else if (srst) begin
            seq <= '0;
        end else if (we) begin
            seq <= seq_w;
        end else if (start && (mode == status_gen_pkg::MODE_AUTO_INC)) begin
            seq <= seq + 1'b1; // wraps at 63
        end
    end

    // pending request from a write with a nonzero mode
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            cmd_pend <= 1'b0;
        end else if (srst) begin
            cmd_pend <= 1'b0;
        end else if (we && (mode_w != status_gen_pkg::MODE_OFF)) begin
            cmd_pend <= 1'b1; // off mode only updates the registers
        end else if (start) begin
            cmd_pend <= 1'b0; // served by this packet
        end
    end

endmodule

`default_nettype wire

// File: hw/status_gen_pkg.sv
// status generator shared definitions
`default_nettype none

package status_gen_pkg;

    // mode field of the command byte
    typedef enum logic [1:0] {
        MODE_OFF       = 2'd0, // no status packets
        MODE_SINGLE    = 2'd1, // one packet per command write
        MODE_AUTO_KEEP = 2'd2, // packet on each status change, seq fixed
        MODE_AUTO_INC  = 2'd3  // packet on each status change, seq += 1
    } status_mode_e;

    // one byte of the address/data bus
    typedef logic [7:0] byte_t;

    // sequence number width, low part of the command byte
    localparam int SEQ_BITS = 6;

    // mode sits above the sequence number, bits 7..6
    localparam int MODE_LSB = 6;

    // total packet length in bytes, address byte included
    // first payload byte carries seq and status[1:0], the rest status[..:2]
    function automatic int packet_bytes(input int payload_bits);
        int nbytes;
        nbytes = (payload_bits + 21) / 8; // 15 bits -> 4 bytes
        return nbytes;
    endfunction

endpackage

`default_nettype wire
